//--- Makefile
VERILATOR ?= verilator
TOP       := tb_decode_stage
FILELIST  := decode_stage.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- decode_stage.f
rtl/common.sv
rtl/fetch_if.sv
rtl/decode_if.sv
rtl/fetch_buffer.sv
rtl/compressed.sv
rtl/instruction_decode.sv
rtl/decode_register.sv
rtl/decode_stage.sv
testbench/tb_decode_stage.sv

//--- rtl/common.sv
package common;

        localparam int INSTRUCTION_WIDTH = 32;
        localparam int IMM_WIDTH = 21;
        localparam int PC_WIDTH = 32;

        typedef logic [INSTRUCTION_WIDTH-1:0] instruction_t;
        typedef logic [IMM_WIDTH-1:0] imm_t;
        typedef logic [PC_WIDTH-1:0] pc_t;
        typedef logic [4:0] reg_index_t;

        localparam pc_t RESET_PC = '0;

        // Instruction format, as seen by the execute stage.
        typedef enum logic [2:0] {
                R_TYPE,
                I_TYPE,
                S_TYPE,
                B_TYPE,
                U_TYPE,
                J_TYPE,
                SYS_TYPE
        } instruction_op_type;

        // RV32 major opcodes.
        localparam logic [6:0] OP = 7'b0110011;
        localparam logic [6:0] OP_FP = 7'b1010011;
        localparam logic [6:0] MADD = 7'b1000011;
        localparam logic [6:0] MSUB = 7'b1000111;
        localparam logic [6:0] NMSUB = 7'b1001011;
        localparam logic [6:0] NMADD = 7'b1001111;
        localparam logic [6:0] OP_IMM = 7'b0010011;
        localparam logic [6:0] JALR = 7'b1100111;
        localparam logic [6:0] LOAD = 7'b0000011;
        localparam logic [6:0] LOAD_FP = 7'b0000111;
        localparam logic [6:0] STORE = 7'b0100011;
        localparam logic [6:0] STORE_FP = 7'b0100111;
        localparam logic [6:0] BRANCH = 7'b1100011;
        localparam logic [6:0] U_LUI = 7'b0110111;
        localparam logic [6:0] J_JAL = 7'b1101111;
        localparam logic [6:0] SYSTEM = 7'b1110011;

endpackage

//--- rtl/compressed.sv
`timescale 1ns/1ps

module compressed (
        input common::instruction_t mem_instruction,
        output logic is_compressed,
        output common::instruction_t instruction
);

        logic [15:0] c;
        common::reg_index_t rd;
        common::reg_index_t rs2;
        common::reg_index_t rd_p;  // Short register fields map to x8..x15.
        common::reg_index_t rs1_p;
        logic [11:0] mem_off;
        logic [11:1] j_off;
        logic [8:1] b_off;
        logic [11:0] ci_imm;
        common::instruction_t expanded;

        assign c = mem_instruction[15:0];
        assign is_compressed = mem_instruction[1:0] != 2'b11;

        assign rd = c[11:7];
        assign rs2 = c[6:2];
        assign rd_p = {2'b01, c[4:2]};
        assign rs1_p = {2'b01, c[9:7]};

        // Word offset for C.LW and C.SW.
        assign mem_off = {5'b0, c[5], c[12:10], c[6], 2'b00};
        assign j_off = {c[12], c[8], c[10], c[9], c[6], c[7], c[2], c[11], c[5], c[4], c[3]};
        assign b_off = {c[12], c[6], c[5], c[2], c[11], c[10], c[4], c[3]};
        assign ci_imm = {{6{c[12]}}, c[12], c[6:2]};

        always_comb begin
                expanded = '0;  // Unsupported patterns.
                case ({c[1:0], c[15:13]})
                        5'b00_010:  // C.LW
                                expanded = {mem_off, rs1_p, 3'b010, rd_p, common::LOAD};
                        5'b00_110:  // C.SW
                                expanded = {mem_off[11:5], rd_p, rs1_p, 3'b010,
                                            mem_off[4:0], common::STORE};
                        5'b01_000:  // C.ADDI
                                expanded = {ci_imm, rd, 3'b000, rd, common::OP_IMM};
                        5'b01_010:  // C.LI
                                expanded = {ci_imm, 5'd0, 3'b000, rd, common::OP_IMM};
                        5'b01_011: begin
                                // rd of x2 is C.ADDI16SP.
                                if (rd != 5'd2)
                                        expanded = {{14{c[12]}}, c[12], c[6:2], rd,
                                                    common::U_LUI};
                        end
                        5'b01_101:  // C.J
                                expanded = {j_off[11], j_off[10:1], j_off[11],
                                            {8{j_off[11]}}, 5'd0, common::J_JAL};
                        5'b01_110,
                        5'b01_111:  // C.BEQZ, C.BNEZ
                                expanded = {b_off[8], {3{b_off[8]}}, b_off[7:5], 5'd0,
                                            rs1_p, 2'b00, c[13], b_off[4:1], b_off[8],
                                            common::BRANCH};
                        5'b10_000: begin
                                if (!c[12])  // C.SLLI, shamt below 32.
                                        expanded = {7'b0, rs2, rd, 3'b001, rd,
                                                    common::OP_IMM};
                        end
                        5'b10_100: begin
                                if (!c[12]) begin
                                        if (rs2 != 5'd0)  // C.MV.
                                                expanded = {7'b0, rs2, 5'd0, 3'b000, rd,
                                                            common::OP};
                                        else if (rd != 5'd0)  // C.JR.
                                                expanded = {12'b0, rd, 3'b000, 5'd0,
                                                            common::JALR};
                                end else if (rs2 != 5'd0) begin
                                        // C.ADD.
                                        expanded = {7'b0, rs2, rd, 3'b000, rd, common::OP};
                                end
                        end
                        default: expanded = '0;
                endcase
        end

        assign instruction = is_compressed ? expanded : mem_instruction;

endmodule

//--- rtl/decode_if.sv
`timescale 1ns/1ps

interface decode_if;

        logic valid;
        common::pc_t pc;
        logic is_compressed;
        logic [6:0] opcode;
        common::instruction_op_type optype;
        common::reg_index_t rd;
        common::reg_index_t rs1;
        common::reg_index_t rs2;
        logic [2:0] funct3;
        logic [6:0] funct7;
        common::imm_t imm;

        modport decode (
                output valid, pc, is_compressed, opcode, optype,
                output rd, rs1, rs2, funct3, funct7, imm
        );

        modport issue (
                input valid, pc, is_compressed, opcode, optype,
                input rd, rs1, rs2, funct3, funct7, imm
        );

endinterface

//--- rtl/decode_register.sv
`timescale 1ns/1ps

module decode_register (
        input logic clk,
        input logic reset,
        decode_if.issue decoded,
        output logic dec_valid,
        output common::pc_t dec_pc,
        output logic dec_is_compressed,
        output logic [6:0] dec_opcode,
        output common::instruction_op_type dec_optype,
        output common::reg_index_t dec_rd,
        output common::reg_index_t dec_rs1,
        output common::reg_index_t dec_rs2,
        output logic [2:0] dec_funct3,
        output logic [6:0] dec_funct7,
        output common::imm_t dec_imm
);

        always_ff @(posedge clk) begin
                if (reset)
                        dec_valid <= 1'b0;
                else
                        dec_valid <= decoded.valid;
        end

        // Fields follow every edge, qualified by dec_valid.
        always_ff @(posedge clk) begin
                dec_pc <= decoded.pc;
                dec_is_compressed <= decoded.is_compressed;
                dec_opcode <= decoded.opcode;
                dec_optype <= decoded.optype;
                dec_rd <= decoded.rd;
                dec_rs1 <= decoded.rs1;
                dec_rs2 <= decoded.rs2;
                dec_funct3 <= decoded.funct3;
                dec_funct7 <= decoded.funct7;
                dec_imm <= decoded.imm;
        end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
        input logic clk,
        input logic reset,
        input logic mem_valid,
        input common::instruction_t mem_instruction,
        input logic redirect,
        input common::pc_t redirect_pc,
        output logic dec_valid,
        output common::pc_t dec_pc,
        output logic dec_is_compressed,
        output logic [6:0] dec_opcode,
        output common::instruction_op_type dec_optype,
        output common::reg_index_t dec_rd,
        output common::reg_index_t dec_rs1,
        output common::reg_index_t dec_rs2,
        output logic [2:0] dec_funct3,
        output logic [6:0] dec_funct7,
        output common::imm_t dec_imm
);

        fetch_if fetch_bus ();
        decode_if decode_bus ();

        fetch_buffer u_fetch_buffer (
                .clk(clk),
                .reset(reset),
                .mem_valid(mem_valid),
                .mem_instruction(mem_instruction),
                .redirect(redirect),
                .redirect_pc(redirect_pc),
                .fetch(fetch_bus)
        );

        instruction_decode u_instruction_decode (
                .fetch(fetch_bus),
                .decoded(decode_bus)
        );

        decode_register u_decode_register (
                .clk(clk),
                .reset(reset),
                .decoded(decode_bus),
                .dec_valid(dec_valid),
                .dec_pc(dec_pc),
                .dec_is_compressed(dec_is_compressed),
                .dec_opcode(dec_opcode),
                .dec_optype(dec_optype),
                .dec_rd(dec_rd),
                .dec_rs1(dec_rs1),
                .dec_rs2(dec_rs2),
                .dec_funct3(dec_funct3),
                .dec_funct7(dec_funct7),
                .dec_imm(dec_imm)
        );

endmodule

//--- rtl/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer (
        input logic clk,
        input logic reset,
        input logic mem_valid,
        input common::instruction_t mem_instruction,
        input logic redirect,
        input common::pc_t redirect_pc,
        fetch_if.fetch fetch
);

        // Counter holds the address of the word in the fetch register.
        common::pc_t pc;
        logic valid;
        common::instruction_t instruction;
        common::pc_t step;

        assign step = fetch.is_compressed ? common::pc_t'(2) : common::pc_t'(4);

        always_ff @(posedge clk) begin
                if (reset) begin
                        pc <= common::RESET_PC;
                        valid <= 1'b0;
                end else if (redirect) begin
                        pc <= redirect_pc;
                        valid <= 1'b0;  // Drop a strobe in this cycle.
                end else begin
                        if (valid)
                                pc <= pc + step;
                        valid <= mem_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (mem_valid)
                        instruction <= mem_instruction;
        end

        assign fetch.valid = valid && !redirect;  // Squash the held word.
        assign fetch.instruction = instruction;
        assign fetch.pc = pc;

endmodule

//--- rtl/fetch_if.sv
`timescale 1ns/1ps

interface fetch_if;

        logic valid;
        common::instruction_t instruction;
        common::pc_t pc;
        logic is_compressed;  // Length feedback from the decoder.

        modport fetch (
                output valid,
                output instruction,
                output pc,
                input is_compressed
        );

        modport decode (
                input valid,
                input instruction,
                input pc,
                output is_compressed
        );

endinterface

//--- rtl/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode (
        fetch_if.decode fetch,
        decode_if.decode decoded
);

        common::instruction_t instruction;
        logic is_compressed;
        common::instruction_op_type optype;

        compressed u_compressed (
                .mem_instruction(fetch.instruction),
                .is_compressed(is_compressed),
                .instruction(instruction)
        );

        always_comb begin
                case (instruction[6:0])
                        common::OP, common::OP_FP, common::MADD,
                        common::MSUB, common::NMSUB, common::NMADD:
                                optype = common::R_TYPE;
                        common::OP_IMM, common::JALR, common::LOAD, common::LOAD_FP:
                                optype = common::I_TYPE;
                        common::STORE, common::STORE_FP:
                                optype = common::S_TYPE;
                        common::BRANCH: optype = common::B_TYPE;
                        common::U_LUI: optype = common::U_TYPE;
                        common::J_JAL: optype = common::J_TYPE;
                        common::SYSTEM: optype = common::SYS_TYPE;
                        default: optype = common::R_TYPE;
                endcase
        end

        always_comb begin
                case (optype)
                        common::I_TYPE:
                                decoded.imm = {{9{instruction[31]}}, instruction[31:20]};
                        common::S_TYPE:
                                decoded.imm = {{9{instruction[31]}}, instruction[31:25],
                                               instruction[11:7]};
                        common::B_TYPE:
                                decoded.imm = {{8{instruction[31]}}, instruction[31],
                                               instruction[7], instruction[30:25],
                                               instruction[11:8], 1'b0};
                        common::U_TYPE:
                                decoded.imm = {1'b0, instruction[31:12]};  // Unshifted.
                        common::J_TYPE:
                                decoded.imm = {instruction[31], instruction[19:12],
                                               instruction[20], instruction[30:21], 1'b0};
                        default: decoded.imm = '0;
                endcase
        end

        // Fixed RV32 field positions.
        assign decoded.opcode = instruction[6:0];
        assign decoded.rd = instruction[11:7];
        assign decoded.funct3 = instruction[14:12];
        assign decoded.rs1 = instruction[19:15];
        assign decoded.rs2 = instruction[24:20];
        assign decoded.funct7 = instruction[31:25];
        assign decoded.optype = optype;

        assign decoded.valid = fetch.valid;
        assign decoded.pc = fetch.pc;
        assign decoded.is_compressed = is_compressed;
        assign fetch.is_compressed = is_compressed;  // Sets the counter step.

endmodule

//--- testbench/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;

        localparam int RANDOM_COUNT = 60;
        // Directed tests with drain time, then random words with gaps of up to 2 cycles.
        localparam int STIMULUS_CYCLES = 160 + RANDOM_COUNT * 3;
        localparam int TIMEOUT_NS = STIMULUS_CYCLES * 4 + 400;

        typedef struct {
                common::pc_t pc;
                logic is_compressed;
                logic [6:0] opcode;
                common::instruction_op_type optype;
                common::reg_index_t rd;
                common::reg_index_t rs1;
                common::reg_index_t rs2;
                logic [2:0] funct3;
                logic [6:0] funct7;
                common::imm_t imm;
                int due;  // Cycle count at which dec_valid is expected.
        } expected_t;

        logic clk;
        logic reset;
        logic mem_valid;
        common::instruction_t mem_instruction;
        logic redirect;
        common::pc_t redirect_pc;
        logic dec_valid;
        common::pc_t dec_pc;
        logic dec_is_compressed;
        logic [6:0] dec_opcode;
        common::instruction_op_type dec_optype;
        common::reg_index_t dec_rd;
        common::reg_index_t dec_rs1;
        common::reg_index_t dec_rs2;
        logic [2:0] dec_funct3;
        logic [6:0] dec_funct7;
        common::imm_t dec_imm;

        expected_t expected[$];
        common::pc_t model_pc;
        int cycle = 0;
        int errors = 0;
        int checks = 0;
        int tests = 0;
        int test_start_errors = 0;

        decode_stage u_decode_stage (.*);

        function automatic common::instruction_t itype_word(logic [11:0] imm, logic [4:0] rs1,
                                                            logic [2:0] f3, logic [4:0] rd,
                                                            logic [6:0] op);
                return {imm, rs1, f3, rd, op};
        endfunction

        function automatic common::instruction_t stype_word(logic [11:0] imm, logic [4:0] rs2,
                                                            logic [4:0] rs1, logic [2:0] f3,
                                                            logic [6:0] op);
                return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
        endfunction

        function automatic common::instruction_t branch_word(logic [12:0] imm, logic [4:0] rs2,
                                                             logic [4:0] rs1, logic [2:0] f3,
                                                             logic [6:0] op);
                return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
        endfunction

        function automatic common::instruction_t jump_word(logic [20:0] imm, logic [4:0] rd,
                                                           logic [6:0] op);
                return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
        endfunction

        function automatic logic [15:0] pack_rvc(logic [2:0] f3, logic b12, logic [4:0] hi,
                                                 logic [4:0] lo, logic [1:0] op);
                return {f3, b12, hi, lo, op};
        endfunction

        // RVC subset expansion, per the compressed ISA encodings.
        function automatic common::instruction_t expand_rvc(logic [15:0] c);
                logic [4:0] rd;
                logic [4:0] rs2;
                logic [4:0] rdc;
                logic [4:0] rs1c;
                logic [11:0] six;
                logic [11:0] uimm;
                common::instruction_t w;
                rd = c[11:7];
                rs2 = c[6:2];
                rdc = {2'b01, c[4:2]};
                rs1c = {2'b01, c[9:7]};
                six = 12'($signed({c[12], c[6:2]}));
                uimm = {5'd0, c[5], c[12:10], c[6], 2'b00};
                w = '0;
                case ({c[15:13], c[1:0]})
                        5'b010_00: w = itype_word(uimm, rs1c, 3'b010, rdc, common::LOAD);
                        5'b110_00: w = stype_word(uimm, rdc, rs1c, 3'b010, common::STORE);
                        5'b000_01: w = itype_word(six, rd, 3'b000, rd, common::OP_IMM);
                        5'b010_01: w = itype_word(six, 5'd0, 3'b000, rd, common::OP_IMM);
                        5'b011_01: if (rd != 5'd2)
                                w = {20'($signed({c[12], c[6:2]})), rd, common::U_LUI};
                        5'b101_01: w = jump_word(21'($signed({c[12], c[8], c[10:9], c[6], c[7],
                                        c[2], c[11], c[5:3], 1'b0})), 5'd0, common::J_JAL);
                        5'b110_01, 5'b111_01: w = branch_word(13'($signed({c[12], c[6:5], c[2],
                                        c[11:10], c[4:3], 1'b0})), 5'd0, rs1c, {2'b00, c[13]},
                                        common::BRANCH);
                        5'b000_10: if (!c[12])
                                w = {7'd0, rs2, rd, 3'b001, rd, common::OP_IMM};
                        5'b100_10: begin
                                if (!c[12] && rs2 != 5'd0)
                                        w = {7'd0, rs2, 5'd0, 3'b000, rd, common::OP};
                                else if (!c[12] && rd != 5'd0)
                                        w = itype_word(12'd0, rd, 3'b000, 5'd0, common::JALR);
                                else if (c[12] && rs2 != 5'd0)
                                        w = {7'd0, rs2, rd, 3'b000, rd, common::OP};
                        end
                        default: w = '0;
                endcase
                return w;
        endfunction

        // Expected decode of one fetched word at a given pc.
        function automatic expected_t predict(common::instruction_t word, common::pc_t pc);
                expected_t e;
                common::instruction_t w;
                e.is_compressed = word[1:0] != 2'b11;
                w = e.is_compressed ? expand_rvc(word[15:0]) : word;
                e.pc = pc;
                e.opcode = w[6:0];
                e.rd = w[11:7];
                e.funct3 = w[14:12];
                e.rs1 = w[19:15];
                e.rs2 = w[24:20];
                e.funct7 = w[31:25];
                case (w[6:0])
                        common::OP_IMM, common::JALR, common::LOAD, common::LOAD_FP:
                                e.optype = common::I_TYPE;
                        common::STORE, common::STORE_FP: e.optype = common::S_TYPE;
                        common::BRANCH: e.optype = common::B_TYPE;
                        common::U_LUI: e.optype = common::U_TYPE;
                        common::J_JAL: e.optype = common::J_TYPE;
                        common::SYSTEM: e.optype = common::SYS_TYPE;
                        default: e.optype = common::R_TYPE;
                endcase
                case (e.optype)
                        common::I_TYPE: e.imm = 21'($signed(w[31:20]));
                        common::S_TYPE: e.imm = 21'($signed({w[31:25], w[11:7]}));
                        common::B_TYPE:
                                e.imm = 21'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
                        common::U_TYPE: e.imm = {1'b0, w[31:12]};
                        common::J_TYPE: e.imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
                        default: e.imm = '0;
                endcase
                e.due = 0;
                return e;
        endfunction

        task automatic check_field(string name, logic [31:0] exp, logic [31:0] act);
                checks++;
                assert (act === exp) else begin
                        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
                        errors++;
                end
        endtask

        task automatic send_word(common::instruction_t word);
                expected_t e;
                e = predict(word, model_pc);
                e.due = cycle + 2;
                expected.push_back(e);
                model_pc = model_pc + (e.is_compressed ? 32'd2 : 32'd4);
                mem_valid = 1'b1;
                mem_instruction = word;
                @(negedge clk);
                mem_valid = 1'b0;
        endtask

        task automatic send_redirect(common::pc_t pc, logic strobe, common::instruction_t word);
                // The word held in the fetch register is squashed.
                if (expected.size() != 0 && expected[$].due == cycle + 1)
                        expected.delete(expected.size() - 1);
                model_pc = pc;  // A strobe in this cycle is dropped.
                redirect = 1'b1;
                redirect_pc = pc;
                mem_valid = strobe;
                mem_instruction = word;
                @(negedge clk);
                redirect = 1'b0;
                mem_valid = 1'b0;
        endtask

        task automatic end_test(string name);
                int waited;
                waited = 0;
                while (expected.size() != 0 && waited < 10) begin
                        @(negedge clk);
                        waited++;
                end
                if (expected.size() != 0) begin
                        $display("%0d instructions never reached the outputs", expected.size());
                        errors += expected.size();
                        expected.delete();
                end
                repeat (3) @(negedge clk);
                tests++;
                $display("Test %0d %s: %0d errors", tests, name, errors - test_start_errors);
                test_start_errors = errors;
        endtask

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        always @(posedge clk) cycle <= cycle + 1;

        initial begin
                #(TIMEOUT_NS);
                $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
                $display("FAIL: see errors above");
                $finish;
        end

        // Outputs settle after the rising edge; sample on the falling one.
        initial begin
                expected_t e;
                forever begin
                        @(negedge clk);
                        if (dec_valid === 1'b1) begin
                                if (expected.size() == 0) begin
                                        $display("Unexpected instruction at %0t with pc %h",
                                                 $time, dec_pc);
                                        errors++;
                                end else begin
                                        e = expected.pop_front();
                                        check_field("dec_valid cycle", 32'(e.due), 32'(cycle));
                                        check_field("dec_pc", e.pc, dec_pc);
                                        check_field("dec_is_compressed", 32'(e.is_compressed),
                                                    32'(dec_is_compressed));
                                        check_field("dec_opcode", 32'(e.opcode), 32'(dec_opcode));
                                        check_field("dec_optype", 32'(e.optype), 32'(dec_optype));
                                        check_field("dec_rd", 32'(e.rd), 32'(dec_rd));
                                        check_field("dec_rs1", 32'(e.rs1), 32'(dec_rs1));
                                        check_field("dec_rs2", 32'(e.rs2), 32'(dec_rs2));
                                        check_field("dec_funct3", 32'(e.funct3), 32'(dec_funct3));
                                        check_field("dec_funct7", 32'(e.funct7), 32'(dec_funct7));
                                        check_field("dec_imm", 32'(e.imm), 32'(dec_imm));
                                end
                        end
                end
        end

        initial begin
                common::instruction_t word;
                int gap;
                void'($urandom(32'hbb));
                reset = 1'b1;
                mem_valid = 1'b0;
                mem_instruction = '0;
                redirect = 1'b0;
                redirect_pc = '0;
                model_pc = common::RESET_PC;
                repeat (2) @(negedge clk);
                reset = 1'b0;

                repeat (3) begin
                        @(negedge clk);
                        check_field("dec_valid", 32'd0, 32'(dec_valid));
                end
                send_word(itype_word(12'd1, 5'd1, 3'b000, 5'd1, common::OP_IMM));
                end_test("reset and first pc");

                send_word({7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3, common::OP});
                send_word(itype_word(12'hffb, 5'd6, 3'b000, 5'd5, common::OP_IMM));
                send_word(stype_word(12'hff8, 5'd7, 5'd2, 3'b010, common::STORE));
                send_word(branch_word(13'h1ff0, 5'd2, 5'd1, 3'b001, common::BRANCH));
                send_word({20'h80001, 5'd9, common::U_LUI});
                send_word(jump_word(21'h1ff800, 5'd1, common::J_JAL));
                send_word(32'h30529073);
                send_word(32'h12345097);  // AUIPC.
                end_test("32-bit formats");

                send_word({16'($urandom), pack_rvc(3'b000, 1'b1, 5'd8, 5'b11111, 2'b01)});
                send_word({16'($urandom), pack_rvc(3'b010, 1'b1, 5'd10, 5'b10000, 2'b01)});
                send_word({16'($urandom), pack_rvc(3'b011, 1'b1, 5'd12, 5'b00001, 2'b01)});
                send_word({16'($urandom), pack_rvc(3'b000, 1'b0, 5'd9, 5'd31, 2'b10)});
                send_word({16'($urandom), pack_rvc(3'b010, 1'b1, 5'b01011, 5'b11010, 2'b00)});
                send_word({16'($urandom), pack_rvc(3'b110, 1'b0, 5'b11001, 5'b01101, 2'b00)});
                send_word({16'($urandom), pack_rvc(3'b101, 1'b1, 5'b10110, 5'b01101, 2'b01)});
                send_word({16'($urandom), pack_rvc(3'b110, 1'b1, 5'b01100, 5'b10110, 2'b01)});
                send_word({16'($urandom), pack_rvc(3'b111, 1'b0, 5'b10010, 5'b01001, 2'b01)});
                send_word({16'($urandom), pack_rvc(3'b100, 1'b0, 5'd11, 5'd14, 2'b10)});
                send_word({16'($urandom), pack_rvc(3'b100, 1'b1, 5'd11, 5'd14, 2'b10)});
                send_word({16'($urandom), pack_rvc(3'b100, 1'b0, 5'd1, 5'd0, 2'b10)});
                send_word({16'($urandom), pack_rvc(3'b100, 1'b1, 5'd1, 5'd0, 2'b10)});
                send_word({16'($urandom), pack_rvc(3'b011, 1'b0, 5'd2, 5'b00100, 2'b01)});
                end_test("compressed patterns");

                repeat (RANDOM_COUNT) begin
                        word = $urandom;
                        if ($urandom % 2 == 0)
                                word[1:0] = 2'b11;
                        else if (word[1:0] == 2'b11)
                                word[1:0] = 2'b01;
                        send_word(word);
                        gap = $urandom % 3;
                        repeat (gap) @(negedge clk);
                end
                end_test("random mix");

                // The load sits in the decode register and retires. The C.ADDI is squashed.
                send_word(itype_word(12'd4, 5'd2, 3'b010, 5'd8, common::LOAD));
                send_word({16'd0, pack_rvc(3'b000, 1'b0, 5'd8, 5'd3, 2'b01)});
                send_redirect(32'h0000_1000, 1'b0, '0);
                send_word({16'd0, pack_rvc(3'b010, 1'b0, 5'd9, 5'd7, 2'b01)});
                send_word(itype_word(12'h800, 5'd3, 3'b000, 5'd4, common::OP_IMM));
                end_test("redirect");

                send_word(itype_word(12'd8, 5'd1, 3'b000, 5'd2, common::OP_IMM));
                send_redirect(32'h0000_2000, 1'b1, 32'h00000013);
                repeat (4) @(negedge clk);
                send_word({20'h12345, 5'd6, common::U_LUI});
                end_test("strobe with redirect");

                $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
                if (errors == 0)
                        $display("PASS: all tests");
                else
                        $display("FAIL: see errors above");
                $finish;
        end

endmodule
